// ==== filelist.f ====
hdl/irqc_pkg.sv
hdl/irqc_timer.sv
hdl/irqc_latch.sv
hdl/irqc_priority.sv
hdl/irqc_entry_fsm.sv
hdl/irqc_top.sv
tests/irqc_asserts.sv
tests/irqc_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run irqc_tb, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module irqc_tb -Mdir obj_dir -o irqc_sim
	./obj_dir/irqc_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/irqc_tb.sv ====
`timescale 1ns/10ps

module irqc_tb;

   localparam int IRQW = 10;
   localparam int LAW  = 32;
   localparam int TW   = 16;

   localparam int reset_cycles = 16;
   localparam int reg_cycles   = 400;        // Register traffic, interrupts off
   localparam int irq_cycles   = 1500;       // Edges, nesting, stalls
   localparam int timer_cycles = 1200;
   localparam int total_cycles = reset_cycles + reg_cycles + irq_cycles + timer_cycles + 4;

   logic                clk = 1'b0;
   logic                nreset;
   logic                reg_write;
   irqc_pkg::reg_addr_t reg_addr;
   irqc_pkg::reg_data_t reg_wdata;
   logic [IRQW-2:0]     ext_irq;
   logic [LAW-1:0]      pc_next;
   logic                rti;
   logic                global_irq_en;
   logic                core_wait;
   logic                flush;
   logic                irq;
   logic [LAW-1:0]      irq_addr;
   logic [LAW-1:0]      iret_reg;
   logic [IRQW-1:0]     imask_reg;
   logic [IRQW-1:0]     ilat_reg;
   logic [IRQW-1:0]     ipend_reg;

   // ####################################################################
   // Reference model state
   // ####################################################################
   logic [IRQW-1:0]        m_src_q;        // Sampled sources
   logic [IRQW-1:0]        m_shadow;
   logic [IRQW-1:0]        m_ilat;
   logic [IRQW-1:0]        m_imask;
   logic [IRQW-1:0]        m_ipend;
   logic [IRQW-1:0]        m_entry;        // Captured index
   logic [LAW-1:0]         m_iret;
   logic [TW-1:0]          m_reload;
   logic [TW-1:0]          m_count;
   logic                   m_timer_irq;
   irqc_pkg::entry_state_t m_state;

   integer seed;
   int     errors = 0;
   int     checks = 0;
   int     entries = 0;
   int     timer_entries = 0;
   int     max_depth = 0;
   int     stall_left = 0;                 // Remaining core_wait cycles

   irqc_top #(.IRQW(IRQW), .LAW(LAW), .TW(TW)) dut (.*);

   always #2 clk = ~clk;                   // 4 ns period

   function automatic int roll();
      roll = $unsigned($random(seed)) % 100;
   endfunction

   function automatic int lowest_index(input logic [IRQW-1:0] v);
      lowest_index = -1;
      for (int i = IRQW - 1; i >= 0; i--)
         if (v[i])
            lowest_index = i;
   endfunction

   function automatic bit write_to(input irqc_pkg::reg_addr_t a);
      write_to = reg_write && (reg_addr == a);
   endfunction

   // Lowest unmasked latched index, only if below every pending level
   function automatic logic [IRQW-1:0] pick_candidate();
      int cand;
      int pend;
      cand = lowest_index(m_ilat & ~m_imask);
      pend = lowest_index(m_ipend);
      pick_candidate = '0;
      if (cand >= 0 && (pend < 0 || cand < pend))
         pick_candidate[cand] = 1'b1;
   endfunction

   task automatic reset_model();
      m_src_q     = '0;
      m_shadow    = '0;
      m_ilat      = '0;
      m_imask     = '0;
      m_ipend     = '0;
      m_entry     = '0;
      m_iret      = '0;
      m_reload    = '0;
      m_count     = '0;
      m_timer_irq = 1'b0;
      m_state     = irqc_pkg::st_idle;
   endtask

   task automatic step_model();
      logic [IRQW-1:0]        src_event;
      logic [IRQW-1:0]        sel;
      logic [IRQW-1:0]        clr;
      logic [IRQW-1:0]        ilat_n;
      logic [IRQW-1:0]        ipend_n;
      irqc_pkg::entry_state_t state_n;
      bit                     take;
      src_event = m_src_q & ~m_shadow;     // Rising edges
      sel       = pick_candidate();
      take      = (sel != '0) && global_irq_en;
      state_n   = m_state;
      case (m_state)
         irqc_pkg::st_idle:
            if (take)
               state_n = core_wait ? irqc_pkg::st_hold : irqc_pkg::st_entry;
         irqc_pkg::st_hold:
            if (!core_wait)
               state_n = irqc_pkg::st_entry;
         default:
            state_n = irqc_pkg::st_idle;
      endcase
      // Latch, clear beats set, event beats both
      clr    = (m_state == irqc_pkg::st_entry) ? m_entry : '0;
      ilat_n = write_to(irqc_pkg::addr_ilat) ? reg_wdata[IRQW-1:0] : m_ilat;
      if (write_to(irqc_pkg::addr_ilatset))
         ilat_n = ilat_n | reg_wdata[IRQW-1:0];
      if (write_to(irqc_pkg::addr_ilatclr))
         clr = clr | reg_wdata[IRQW-1:0];
      ilat_n = (ilat_n & ~clr) | src_event;
      // Nesting, rti pops innermost level
      ipend_n = m_ipend;
      if (rti && m_ipend != '0)
         ipend_n[lowest_index(m_ipend)] = 1'b0;
      if (m_state == irqc_pkg::st_entry)
      begin
         ipend_n = ipend_n | m_entry;
         entries++;
         if (m_entry[0])
            timer_entries++;
      end
      if ($countones(ipend_n) > max_depth)
         max_depth = $countones(ipend_n);
      if (state_n == irqc_pkg::st_entry)
         m_iret = pc_next;                 // Entry wins over software
      else if (write_to(irqc_pkg::addr_iret))
         m_iret = reg_wdata;
      if (write_to(irqc_pkg::addr_imask))
         m_imask = reg_wdata[IRQW-1:0];
      if (m_state == irqc_pkg::st_idle && take)
         m_entry = sel;
      m_shadow = m_src_q;
      m_src_q  = {ext_irq, m_timer_irq};   // Old timer output
      // Countdown
      if (write_to(irqc_pkg::addr_timer))
      begin
         m_reload    = reg_wdata[TW-1:0];
         m_count     = reg_wdata[TW-1:0];
         m_timer_irq = 1'b0;
      end
      else if (m_reload == '0)
         m_timer_irq = 1'b0;
      else if (m_count == '0)
      begin
         m_count     = m_reload;
         m_timer_irq = 1'b1;
      end
      else
      begin
         m_count     = m_count - 1'b1;
         m_timer_irq = 1'b0;
      end
      m_ilat  = ilat_n;
      m_ipend = ipend_n;
      m_state = state_n;
   endtask

   always @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         reset_model();
      else
         step_model();
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_outputs();
      int          idx;
      logic [31:0] exp_addr;
      bit          exp_flush;
      idx       = lowest_index(m_entry);
      exp_addr  = irqc_pkg::ivt_base + 32'(4 * ((idx < 0) ? 0 : idx));
      exp_flush = (m_state == irqc_pkg::st_idle) && (pick_candidate() != '0) && global_irq_en;
      check_value("flush", 32'(flush), 32'(exp_flush));
      check_value("irq", 32'(irq), 32'(m_state == irqc_pkg::st_entry));
      check_value("irq_addr", irq_addr, exp_addr);
      check_value("iret_reg", iret_reg, m_iret);
      check_value("imask_reg", 32'(imask_reg), 32'(m_imask));
      check_value("ilat_reg", 32'(ilat_reg), 32'(m_ilat));
      check_value("ipend_reg", 32'(ipend_reg), 32'(m_ipend));
   endtask

   // Random core and register traffic for one cycle
   task automatic drive_inputs(input int wr_pct, input int irq_pct, input int rti_pct,
                               input bit irq_on);
      logic [31:0] r;
      logic [31:0] r2;
      r         = $random(seed);
      pc_next   = r;
      reg_write = 1'b0;
      rti       = 1'b0;
      ext_irq   = '0;                      // Pulses give one edge each
      if (roll() < wr_pct)
      begin
         reg_write = 1'b1;
         reg_wdata = $random(seed);
         case (roll() % 5)
            0: reg_addr = irqc_pkg::addr_ilat;
            1: reg_addr = irqc_pkg::addr_ilatset;
            2: reg_addr = irqc_pkg::addr_ilatclr;
            3:
            begin
               reg_addr  = irqc_pkg::addr_imask;
               r2        = $random(seed);
               reg_wdata = reg_wdata & r2 & 32'($random(seed));  // Sparse mask
            end
            default: reg_addr = irqc_pkg::addr_iret;
         endcase
      end
      if (roll() < irq_pct)
      begin
         r  = $random(seed);
         r2 = $random(seed);
         ext_irq = r[IRQW-2:0] & r2[IRQW-2:0];
      end
      if (roll() < rti_pct)
         rti = 1'b1;
      global_irq_en = irq_on && (roll() >= 8);
      if (stall_left > 0)
         stall_left--;
      else if (roll() < 6)
         stall_left = 1 + roll() % 6;      // Stall of 1 to 6 cycles
      core_wait = (stall_left > 0);
   endtask

   task automatic run_phase(input int cycles, input int wr_pct, input int irq_pct,
                            input int rti_pct, input bit irq_on);
      repeat (cycles)
      begin
         @(negedge clk);
         compare_outputs();
         drive_inputs(wr_pct, irq_pct, rti_pct, irq_on);
      end
   endtask

   initial
   begin
      seed          = 32'h1ec4_db1f;
      nreset        = 1'b0;
      reg_write     = 1'b0;
      reg_addr      = '0;
      reg_wdata     = '0;
      ext_irq       = '0;
      pc_next       = '0;
      rti           = 1'b0;
      global_irq_en = 1'b0;
      core_wait     = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      run_phase(reg_cycles, 30, 15, 0, 1'b0);
      run_phase(irq_cycles, 12, 15, 10, 1'b1);
      // Start the timer, reload 6 to 15
      @(negedge clk);
      compare_outputs();
      drive_inputs(0, 0, 0, 1'b1);
      reg_write = 1'b1;
      reg_addr  = irqc_pkg::addr_timer;
      reg_wdata = 32'(6 + roll() % 10);
      run_phase(timer_cycles, 8, 10, 12, 1'b1);
      @(negedge clk);
      compare_outputs();
      if (entries == 0)
      begin
         errors++;
         $display("No interrupt entry happened during the run");
      end
      if (timer_entries == 0)
      begin
         errors++;
         $display("The timer line was never served");
      end
      if (max_depth < 2)
      begin
         errors++;
         $display("Interrupts never nested");
      end
      $display("checks %0d errors %0d entries %0d timer entries %0d max depth %0d",
               checks, errors, entries, timer_entries, max_depth);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(total_cycles * 4 + 400);
      $display("Watchdog expired before the test sequence finished");
      $display("Regression failed");
      $finish;
   end

endmodule

// ==== tests/irqc_asserts.sv ====
`timescale 1ns/10ps

module irqc_asserts #(
   parameter int IRQW = 10
) (
   input  logic                   clk,
   input  logic                   nreset,
   input  irqc_pkg::entry_state_t state,       // Entry FSM state
   input  logic                   irq,
   input  logic [IRQW-1:0]        entry_clr
);

   // ##################################################################
   // Entry strobe shape
   // ##################################################################

   // Core sees exactly one cycle of irq per entry
   a_irq_single: assert property (@(posedge clk) disable iff (!nreset) irq |=> !irq)
      else $error("irq stayed high for more than one cycle");

   // Clear goes to one latch bit at most
   a_clr_onehot: assert property (@(posedge clk) disable iff (!nreset) $onehot0(entry_clr))
      else $error("entry_clr has more than one bit set");

   // No irq while idle
   a_idle_quiet: assert property (@(posedge clk) disable iff (!nreset)
      (state == irqc_pkg::st_idle) |-> !irq)
      else $error("irq high in st_idle");

endmodule

bind irqc_entry_fsm irqc_asserts #(.IRQW(IRQW)) u_asserts (
   .clk       (clk),
   .nreset    (nreset),
   .state     (state),
   .irq       (irq),
   .entry_clr (entry_clr)
);

// ==== hdl/irqc_top.sv ====
`timescale 1ns/10ps

module irqc_top #(
   parameter int IRQW = 10,                   // Interrupt lines including the timer
   parameter int LAW  = 32,                   // Address width
   parameter int TW   = 16                    // Timer width
) (
   input  logic                clk,
   input  logic                nreset,
   // Register writes
   input  logic                reg_write,
   input  irqc_pkg::reg_addr_t reg_addr,
   input  irqc_pkg::reg_data_t reg_wdata,
   // External sources on bits 1 and up
   input  logic [IRQW-2:0]     ext_irq,
   // Core side
   input  logic [LAW-1:0]      pc_next,
   input  logic                rti,
   input  logic                global_irq_en,
   input  logic                core_wait,
   output logic                flush,
   output logic                irq,
   output logic [LAW-1:0]      irq_addr,
   // Register levels
   output logic [LAW-1:0]      iret_reg,
   output logic [IRQW-1:0]     imask_reg,
   output logic [IRQW-1:0]     ilat_reg,
   output logic [IRQW-1:0]     ipend_reg
);

   logic            timer_irq;
   logic [IRQW-1:0] irq_src;                  // Timer owns bit 0
   logic [IRQW-1:0] select;
   logic [IRQW-1:0] entry_clr;

   assign irq_src = {ext_irq, timer_irq};

   // ######################################################################
   // Blocks
   // ######################################################################
   irqc_timer #(.TW(TW)) u_timer (
      .clk       (clk),
      .nreset    (nreset),
      .reg_write (reg_write),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .timer_irq (timer_irq)
   );

   irqc_latch #(.IRQW(IRQW)) u_latch (
      .clk       (clk),
      .nreset    (nreset),
      .reg_write (reg_write),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .irq_src   (irq_src),
      .entry_clr (entry_clr),
      .ilat_reg  (ilat_reg),
      .imask_reg (imask_reg)
   );

   irqc_priority #(.IRQW(IRQW)) u_priority (
      .clk       (clk),
      .nreset    (nreset),
      .ilat_reg  (ilat_reg),
      .imask_reg (imask_reg),
      .entry_clr (entry_clr),
      .rti       (rti),
      .select    (select),
      .ipend_reg (ipend_reg)
   );

   irqc_entry_fsm #(.IRQW(IRQW), .LAW(LAW)) u_fsm (
      .clk           (clk),
      .nreset        (nreset),
      .select        (select),
      .global_irq_en (global_irq_en),
      .core_wait     (core_wait),
      .pc_next       (pc_next),
      .reg_write     (reg_write),
      .reg_addr      (reg_addr),
      .reg_wdata     (reg_wdata),
      .flush         (flush),
      .irq           (irq),
      .irq_addr      (irq_addr),
      .iret_reg      (iret_reg),
      .entry_clr     (entry_clr)
   );

endmodule

// ==== hdl/irqc_entry_fsm.sv ====
`timescale 1ns/10ps

module irqc_entry_fsm #(
   parameter int IRQW = 10,
   parameter int LAW  = 32
) (
   input  logic                clk,
   input  logic                nreset,
   input  logic [IRQW-1:0]     select,         // One-hot candidate
   input  logic                global_irq_en,
   input  logic                core_wait,      // Core cannot take an interrupt yet
   input  logic [LAW-1:0]      pc_next,        // Return address from the core
   input  logic                reg_write,
   input  irqc_pkg::reg_addr_t reg_addr,
   input  irqc_pkg::reg_data_t reg_wdata,
   output logic                flush,
   output logic                irq,
   output logic [LAW-1:0]      irq_addr,
   output logic [LAW-1:0]      iret_reg,
   output logic [IRQW-1:0]     entry_clr
);

   irqc_pkg::entry_state_t state;
   irqc_pkg::entry_state_t state_nxt;
   logic [IRQW-1:0]        entry_q;        // Captured index, one-hot
   logic [LAW-1:0]         vec_offset;
   logic                   take;
   logic                   wr_iret;

   assign wr_iret = reg_write & (reg_addr == irqc_pkg::addr_iret);
   assign take    = (|select) & global_irq_en;
   assign flush   = (state == irqc_pkg::st_idle) & take;   // Drain pipe before entry

   // ######################################################################
   // State machine
   // ######################################################################
   always_comb
   begin
      state_nxt = state;
      case (state)
         irqc_pkg::st_idle:
         begin
            if (take)
               state_nxt = core_wait ? irqc_pkg::st_hold : irqc_pkg::st_entry;
         end
         irqc_pkg::st_hold:
         begin
            if (!core_wait)
               state_nxt = irqc_pkg::st_entry;   // First edge after wait drops
         end
         default:
            state_nxt = irqc_pkg::st_idle;       // Entry lasts one cycle
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state   <= irqc_pkg::st_idle;
         entry_q <= '0;
      end
      else
      begin
         state <= state_nxt;
         if (flush)
            entry_q <= select;                   // Kept through hold
      end
   end

   assign irq       = (state == irqc_pkg::st_entry);
   assign entry_clr = {IRQW{irq}} & entry_q;

   // Vector address
   always_comb
   begin
      vec_offset = '0;
      for (int i = 0; i < IRQW; i++)
         if (entry_q[i])
            vec_offset = vec_offset | LAW'(4 * i);
   end

   assign irq_addr = LAW'(irqc_pkg::ivt_base) + vec_offset;

   // Return address where entry beats a software write
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         iret_reg <= '0;
      else if (state_nxt == irqc_pkg::st_entry)
         iret_reg <= pc_next;
      else if (wr_iret)
         iret_reg <= LAW'(reg_wdata);
   end

endmodule

// ==== hdl/irqc_priority.sv ====
`timescale 1ns/10ps

module irqc_priority #(
   parameter int IRQW = 10
) (
   input  logic            clk,
   input  logic            nreset,
   input  logic [IRQW-1:0] ilat_reg,
   input  logic [IRQW-1:0] imask_reg,
   input  logic [IRQW-1:0] entry_clr,     // Index being entered
   input  logic            rti,           // Return from interrupt strobe
   output logic [IRQW-1:0] select,        // One-hot best candidate
   output logic [IRQW-1:0] ipend_reg      // Nesting stack, one bit per level
);

   localparam logic [IRQW-1:0] lsb_one = {{(IRQW-1){1'b0}}, 1'b1};

   logic [IRQW-1:0] masked;                // Latched and enabled
   logic [IRQW-1:0] masked_low;            // Lowest enabled latched index
   logic [IRQW-1:0] pend_low;              // Lowest active nesting level
   logic [IRQW-1:0] pend_guard;            // Indices allowed to preempt
   logic [IRQW-1:0] ipend_pop;
   logic [IRQW-1:0] ipend_nxt;

   // ######################################################################
   // Candidate pick
   // ######################################################################

   // Index 0 is highest priority
   assign masked = ilat_reg & ~imask_reg;

   // Isolate lowest set bit with two's complement
   assign masked_low = masked & (~masked + lsb_one);

   // Same trick for the innermost active level
   assign pend_low = ipend_reg & (~ipend_reg + lsb_one);

   // Bits strictly below the lowest pending bit
   // Empty ipend wraps to all ones, so everything may enter
   assign pend_guard = pend_low - lsb_one;

   // At most one bit
   assign select = masked_low & pend_guard;

   // ######################################################################
   // Nesting register
   // ######################################################################

   // rti retires the innermost level only
   assign ipend_pop = {IRQW{rti}} & pend_low;

   // Entry pushes a new, strictly lower level
   assign ipend_nxt = (ipend_reg & ~ipend_pop) | entry_clr;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ipend_reg <= '0;
      else
         ipend_reg <= ipend_nxt;            // Depth bounded by IRQW
   end

   // Note the guard makes select lower than every pending bit,
   // so a push never lands on an occupied level

endmodule

// ==== hdl/irqc_latch.sv ====
`timescale 1ns/10ps

module irqc_latch #(
   parameter int IRQW = 10
) (
   input  logic                clk,
   input  logic                nreset,
   input  logic                reg_write,
   input  irqc_pkg::reg_addr_t reg_addr,
   input  irqc_pkg::reg_data_t reg_wdata,
   input  logic [IRQW-1:0]     irq_src,      // Raw source lines with the timer on bit 0
   input  logic [IRQW-1:0]     entry_clr,    // One-hot clear from the entry FSM
   output logic [IRQW-1:0]     ilat_reg,
   output logic [IRQW-1:0]     imask_reg
);

   logic [IRQW-1:0] src_q;                   // Sampled sources
   logic [IRQW-1:0] shadow;                  // Previous sample
   logic [IRQW-1:0] src_event;               // Rising edges
   logic [IRQW-1:0] ilat_base;
   logic [IRQW-1:0] ilat_set;
   logic [IRQW-1:0] ilat_clr;
   logic            wr_ilat;
   logic            wr_ilatset;
   logic            wr_ilatclr;
   logic            wr_imask;

   // Write decode
   assign wr_ilat    = reg_write & (reg_addr == irqc_pkg::addr_ilat);
   assign wr_ilatset = reg_write & (reg_addr == irqc_pkg::addr_ilatset);
   assign wr_ilatclr = reg_write & (reg_addr == irqc_pkg::addr_ilatclr);
   assign wr_imask   = reg_write & (reg_addr == irqc_pkg::addr_imask);

   // ######################################################################
   // Edge detect with a sample stage then shadow
   // ######################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         src_q  <= '0;
         shadow <= '0;
      end
      else
      begin
         src_q  <= irq_src;
         shadow <= src_q;
      end
   end

   assign src_event = src_q & ~shadow;

   // Latch next value
   assign ilat_base = wr_ilat ? reg_wdata[IRQW-1:0] : ilat_reg;  // Direct write replaces
   assign ilat_set  = {IRQW{wr_ilatset}} & reg_wdata[IRQW-1:0];
   assign ilat_clr  = ({IRQW{wr_ilatclr}} & reg_wdata[IRQW-1:0]) | entry_clr;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ilat_reg <= '0;
      else
         ilat_reg <= ((ilat_base | ilat_set) & ~ilat_clr) | src_event;  // Event beats clear
   end

   // Mask register
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         imask_reg <= '0;
      else if (wr_imask)
         imask_reg <= reg_wdata[IRQW-1:0];
   end

endmodule

// ==== hdl/irqc_timer.sv ====
`timescale 1ns/10ps

module irqc_timer #(
   parameter int TW = 16
) (
   input  logic                clk,
   input  logic                nreset,
   input  logic                reg_write,
   input  irqc_pkg::reg_addr_t reg_addr,
   input  irqc_pkg::reg_data_t reg_wdata,
   output logic                timer_irq      // One-cycle pulse per period
);

   logic [TW-1:0] reload;                     // Zero means stopped
   logic [TW-1:0] count;
   logic          wr_timer;
   logic          running;

   assign wr_timer = reg_write & (reg_addr == irqc_pkg::addr_timer);
   assign running  = |reload;

   // ######################################################################
   // Countdown with a period of reload + 1
   // ######################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         reload    <= '0;
         count     <= '0;
         timer_irq <= 1'b0;
      end
      else if (wr_timer)
      begin
         reload    <= reg_wdata[TW-1:0];      // Restart from new value
         count     <= reg_wdata[TW-1:0];
         timer_irq <= 1'b0;
      end
      else if (!running)
         timer_irq <= 1'b0;
      else if (count == '0)
      begin
         count     <= reload;                 // Reload and fire
         timer_irq <= 1'b1;
      end
      else
      begin
         count     <= count - 1'b1;
         timer_irq <= 1'b0;
      end
   end

   // timer_irq drops after one cycle, so each period
   // gives a fresh rising edge to the latch

endmodule

// ==== hdl/irqc_pkg.sv ====
package irqc_pkg;

   // ######################################################################
   // Register access types
   // ######################################################################

   typedef logic [5:0]  reg_addr_t;     // Register address
   typedef logic [31:0] reg_data_t;     // Register write data

   // ######################################################################
   // Register map
   // ######################################################################

   // Interrupt return address
   localparam reg_addr_t addr_iret    = 6'h08;

   // Mask with one bit per line
   localparam reg_addr_t addr_imask   = 6'h09;

   // Direct latch write replaces the whole register
   localparam reg_addr_t addr_ilat    = 6'h0a;

   // Ones in the data set latch bits
   localparam reg_addr_t addr_ilatset = 6'h0b;

   // Ones in the data clear latch bits
   localparam reg_addr_t addr_ilatclr = 6'h0c;

   // Timer reload value in the low bits
   localparam reg_addr_t addr_timer   = 6'h0d;

   // ######################################################################
   // Vector table
   // ######################################################################

   // Vector k sits at ivt_base + 4*k
   localparam logic [31:0] ivt_base = 32'h0000_0040;

   // Entry machine states
   typedef enum logic [1:0] {
      st_idle  = 2'd0,                  // Waiting for a candidate
      st_entry = 2'd1,                  // One cycle of irq to the core
      st_hold  = 2'd2                   // Core busy, index held
   } entry_state_t;

endpackage
